/* compile.f */
src/uart_pkg.sv
src/uart_fifo_if.sv
src/uart_fifo.sv
src/uart_bit_timer.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_regs.sv
src/uart_top.sv
testbench/uart_checker.sv
testbench/tb_uart.sv

/* src/uart_bit_timer.sv */
// Baud tick generator, one tick every divider+1 cycles while run is high
// Changing divider while running shifts the current bit period
`timescale 1ns/1ns
`default_nettype none

module uart_bit_timer import uart_pkg::*; (
    input  logic aclk,
    input  logic aresetn,
    input  logic run,
    input  logic half_first,
    input  div_t divider,
    output logic tick
);

    div_t count;
    div_t target;
    logic half_pend;

    // The first period may be cut in half to land in the middle of a bit
    assign target = half_pend ? (divider >> 1) : divider;
    assign tick   = run && (count == target);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count     <= '0;
            half_pend <= 1'b0;
        end else if (!run) begin
            // Idle, arm the half period for the next start
            count     <= '0;
            half_pend <= half_first;
        end else if (tick) begin
            count     <= '0;
            half_pend <= 1'b0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/uart_fifo.sv */
// First-word-fall-through byte FIFO, single clock
// A push while full and a pull while empty are dropped silently
`timescale 1ns/1ns
`default_nettype none

module uart_fifo import uart_pkg::*; (
    input logic  aclk,
    input logic  aresetn,
    uart_fifo_if.fifo port
);

    byte_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push;
    logic                  do_pull;

    // Qualify the strobes against the flags
    assign do_push = port.push && !port.full;
    assign do_pull = port.pull && !port.empty;

    assign port.full  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign port.empty = (count == '0);
    // The head entry is always visible to the reader
    assign port.rdata = mem[rd_ptr];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pull)
                rd_ptr <= rd_ptr + 1'b1;
            // Occupancy only moves when exactly one side is active
            if (do_push && !do_pull)
                count <= count + 1'b1;
            else if (do_pull && !do_push)
                count <= count - 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge aclk) begin
        if (do_push)
            mem[wr_ptr] <= port.wdata;
    end

endmodule

`default_nettype wire

/* src/uart_fifo_if.sv */
// Handshake between a UART engine and its byte FIFO
// Push and pull are single-cycle strobes, rdata shows the head entry
`timescale 1ns/1ns
`default_nettype none

interface uart_fifo_if import uart_pkg::*; ();

    logic  push;
    byte_t wdata;
    logic  full;
    logic  pull;
    byte_t rdata;
    logic  empty;

    // Producer side
    modport writer (output push, output wdata, input full, input empty);
    // Consumer side
    modport reader (output pull, input rdata, input empty, input full);
    // The storage itself
    modport fifo (input push, input wdata, input pull, output full, output rdata, output empty);

endinterface

`default_nettype wire

/* src/uart_pkg.sv */
// Register map, field positions and widths shared by the UART peripheral
// FIFO_DEPTH must stay a power of two since the FIFO pointers wrap on overflow
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////
    // Bus and data widths
    //////////////////////////////////////////////////

    typedef logic [15:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;
    // A bit period lasts the divider value plus one cycles
    typedef logic [15:0] div_t;

    //////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////

    // RX data sits at the top of the map, anything above reads all ones
    localparam addr_t ADDR_CTRL   = 16'h0000;
    localparam addr_t ADDR_DIV    = 16'h0004;
    localparam addr_t ADDR_TXDATA = 16'h0008;
    localparam addr_t ADDR_RXDATA = 16'h000C;

    localparam int    FIFO_DEPTH    = 4;
    localparam int    FIFO_PTR_W    = $clog2(FIFO_DEPTH);
    localparam div_t  DIV_RESET     = 16'd4;
    localparam word_t UNMAPPED_DATA = '1;
    localparam logic  ENABLE_RESET  = 1'b1;

    // Control bits, read/write
    localparam int CTRL_ENABLE    = 0;
    localparam int CTRL_STOP_MODE = 4;

    // Status bits, read only
    localparam int STAT_BUSY     = 8;
    localparam int STAT_TX_EMPTY = 9;
    localparam int STAT_TX_FULL  = 10;
    localparam int STAT_RX_EMPTY = 11;
    localparam int STAT_RX_FULL  = 12;
    localparam int STAT_RTS      = 13;
    localparam int STAT_CTS      = 14;

endpackage

`default_nettype wire

/* src/uart_regs.sv */
// Register bank behind a request/ready bus, one access at a time
// A TX write on a full FIFO or an RX read on an empty FIFO stalls the bus
`timescale 1ns/1ns
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  slv_en,
    input  logic  slv_wr,
    input  addr_t slv_addr,
    input  word_t slv_wdata,
    input  strb_t slv_strb,
    output word_t slv_rdata,
    output logic  slv_ready,
    uart_fifo_if.writer tx_fifo,
    uart_fifo_if.reader rx_fifo,
    input  logic  tx_busy,
    input  logic  rx_busy,
    input  logic  cts_sync,
    output logic  enable,
    output logic  stop_mode,
    output div_t  divider
);

    typedef enum logic {ST_IDLE, ST_RESPOND} bus_state_t;

    bus_state_t state;
    word_t      status;
    word_t      read_word;
    byte_t      tx_byte;
    logic       serve;
    logic       tx_push;
    logic       rx_pull;

    //////////////////////////////////////////////////
    // Status word
    //////////////////////////////////////////////////

    // Parity, loopback and parity error are not implemented and read zero
    always_comb begin
        status                 = '0;
        status[CTRL_ENABLE]    = enable;
        status[CTRL_STOP_MODE] = stop_mode;
        status[STAT_BUSY]      = tx_busy || rx_busy;
        status[STAT_TX_EMPTY]  = tx_fifo.empty;
        status[STAT_TX_FULL]   = tx_fifo.full;
        status[STAT_RX_EMPTY]  = rx_fifo.empty;
        status[STAT_RX_FULL]   = rx_fifo.full;
        // RTS follows the RX FIFO and drops while it is full
        status[STAT_RTS]       = !rx_fifo.full;
        status[STAT_CTS]       = cts_sync;
    end

    //////////////////////////////////////////////////
    // Request decode
    //////////////////////////////////////////////////

    // Decide whether the pending request can complete this cycle
    always_comb begin
        serve     = 1'b1;
        read_word = UNMAPPED_DATA;
        case (slv_addr)
            ADDR_CTRL: read_word = status;
            ADDR_DIV:  read_word = word_t'(divider);
            ADDR_TXDATA: begin
                serve     = !slv_wr || !tx_fifo.full;
                read_word = word_t'(tx_byte);
            end
            ADDR_RXDATA: begin
                // Writes here have no effect and never wait
                serve     = slv_wr || !rx_fifo.empty;
                read_word = word_t'(rx_fifo.rdata);
            end
            default: serve = 1'b1;
        endcase
        // The cycle after ready the request line is not looked at
        serve = serve && slv_en && (state == ST_IDLE);
    end

    assign slv_ready     = (state == ST_RESPOND);
    assign tx_fifo.push  = tx_push;
    assign tx_fifo.wdata = tx_byte;
    assign rx_fifo.pull  = rx_pull;

    //////////////////////////////////////////////////
    // Control registers and bus FSM
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            enable    <= ENABLE_RESET;
            stop_mode <= 1'b0;
            divider   <= DIV_RESET;
            tx_push   <= 1'b0;
            rx_pull   <= 1'b0;
        end else begin
            // FIFO strobes last one cycle, during the ready cycle
            tx_push <= 1'b0;
            rx_pull <= 1'b0;
            state   <= serve ? ST_RESPOND : ST_IDLE;
            if (serve && slv_wr) begin
                case (slv_addr)
                    ADDR_CTRL: begin
                        if (slv_strb[0]) begin
                            enable    <= slv_wdata[CTRL_ENABLE];
                            stop_mode <= slv_wdata[CTRL_STOP_MODE];
                        end
                    end
                    ADDR_DIV: begin
                        if (slv_strb[0])
                            divider[7:0] <= slv_wdata[7:0];
                        if (slv_strb[1])
                            divider[15:8] <= slv_wdata[15:8];
                    end
                    // The push happens even if the data byte is not strobed
                    ADDR_TXDATA: tx_push <= 1'b1;
                    default: ;
                endcase
            end else if (serve && slv_addr == ADDR_RXDATA) begin
                rx_pull <= 1'b1;
            end
        end
    end

    // Read data and the last TX byte
    always_ff @(posedge aclk) begin
        if (serve)
            slv_rdata <= read_word;
        if (serve && slv_wr && slv_addr == ADDR_TXDATA && slv_strb[0])
            tx_byte <= slv_wdata[7:0];
    end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
// Receive engine, 8 data bits LSB first, no parity, one stop bit checked
// A frame with a low stop bit is dropped without any error flag
`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  logic aclk,
    input  logic aresetn,
    input  logic enable,
    input  div_t divider,
    input  logic uart_rx,
    input  logic uart_cts,
    input  logic rts,
    uart_fifo_if.writer fifo,
    output logic busy,
    output logic cts_sync
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  state;
    logic [1:0] rx_meta;
    logic [1:0] cts_meta;
    logic       rx_prev;
    logic       rx_line;
    logic       fall;
    logic [2:0] bit_idx;
    byte_t      shreg;
    logic       tick;

    //////////////////////////////////////////////////
    // Input synchronizers
    //////////////////////////////////////////////////

    // Both lines idle high, so the flops come out of reset at one
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rx_meta  <= '1;
            cts_meta <= '1;
            rx_prev  <= 1'b1;
        end else begin
            rx_meta  <= {rx_meta[0], uart_rx};
            cts_meta <= {cts_meta[0], uart_cts};
            rx_prev  <= rx_meta[1];
        end
    end

    assign rx_line  = rx_meta[1];
    assign cts_sync = cts_meta[1];
    assign fall     = rx_prev && !rx_line;
    assign busy     = (state != RX_IDLE);

    // Half period first, so every sample lands mid-bit
    uart_bit_timer i_bit_timer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .run        (busy),
        .half_first (1'b1),
        .divider    (divider),
        .tick       (tick)
    );

    //////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= RX_IDLE;
            bit_idx <= '0;
        end else begin
            case (state)
                // A start bit that is high again mid-period was a glitch
                RX_START: if (tick) state <= rx_line ? RX_IDLE : RX_DATA;
                RX_DATA: begin
                    if (tick) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                end
                RX_STOP: if (tick) state <= RX_IDLE;
                default: begin
                    // With the FIFO full, RTS is low and new frames are refused
                    bit_idx <= '0;
                    if (enable && rts && fall)
                        state <= RX_START;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == RX_DATA && tick)
            shreg <= {rx_line, shreg[7:1]};
    end

    // Store the byte only on a valid stop bit
    assign fifo.push  = (state == RX_STOP) && tick && rx_line;
    assign fifo.wdata = shreg;

endmodule

`default_nettype wire

/* src/uart_top.sv */
// UART peripheral top, request/ready register bus and RTS/CTS flow control
// Only 8N1 and 8N2 frames are supported
`timescale 1ns/1ns
`default_nettype none

module uart_top import uart_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    input  logic  slv_en,
    input  logic  slv_wr,
    input  addr_t slv_addr,
    input  word_t slv_wdata,
    input  strb_t slv_strb,
    output word_t slv_rdata,
    output logic  slv_ready,
    input  logic  uart_rx,
    output logic  uart_tx,
    output logic  uart_rts,
    input  logic  uart_cts
);

    logic enable;
    logic stop_mode;
    div_t clock_divider;
    logic tx_busy;
    logic rx_busy;
    logic cts_sync;

    uart_fifo_if tx_fifo_bus ();
    uart_fifo_if rx_fifo_bus ();

    // Ask the remote sender to hold off while the RX FIFO is full
    assign uart_rts = ~rx_fifo_bus.full;

    uart_regs i_uart_regs (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .slv_en    (slv_en),
        .slv_wr    (slv_wr),
        .slv_addr  (slv_addr),
        .slv_wdata (slv_wdata),
        .slv_strb  (slv_strb),
        .slv_rdata (slv_rdata),
        .slv_ready (slv_ready),
        .tx_fifo   (tx_fifo_bus.writer),
        .rx_fifo   (rx_fifo_bus.reader),
        .tx_busy   (tx_busy),
        .rx_busy   (rx_busy),
        .cts_sync  (cts_sync),
        .enable    (enable),
        .stop_mode (stop_mode),
        .divider   (clock_divider)
    );

    uart_fifo i_tx_fifo (.aclk(aclk), .aresetn(aresetn), .port(tx_fifo_bus.fifo));
    uart_fifo i_rx_fifo (.aclk(aclk), .aresetn(aresetn), .port(rx_fifo_bus.fifo));

    uart_tx i_uart_tx (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .enable    (enable),
        .stop_mode (stop_mode),
        .divider   (clock_divider),
        .cts_sync  (cts_sync),
        .fifo      (tx_fifo_bus.reader),
        .busy      (tx_busy),
        .uart_tx   (uart_tx)
    );

    uart_rx i_uart_rx (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .enable   (enable),
        .divider  (clock_divider),
        .uart_rx  (uart_rx),
        .uart_cts (uart_cts),
        .rts      (uart_rts),
        .fifo     (rx_fifo_bus.writer),
        .busy     (rx_busy),
        .cts_sync (cts_sync)
    );

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// Transmit engine, 8 data bits LSB first, no parity, one or two stop bits
// Disabling the engine lets the current frame finish
`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  logic aclk,
    input  logic aresetn,
    input  logic enable,
    input  logic stop_mode,
    input  div_t divider,
    input  logic cts_sync,
    uart_fifo_if.reader fifo,
    output logic busy,
    output logic uart_tx
);

    typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_STOP} tx_state_t;

    tx_state_t  state;
    byte_t      shreg;
    logic [3:0] bit_idx;
    logic       tick;
    logic       start;

    // A frame starts only from idle with the remote side ready and data queued
    assign start     = (state == TX_IDLE) && enable && cts_sync && !fifo.empty;
    // Pop the byte in the same cycle it is loaded into the shift register
    assign fifo.pull = start;
    assign busy      = (state != TX_IDLE);

    uart_bit_timer i_bit_timer (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .run        (busy),
        .half_first (1'b0),
        .divider    (divider),
        .tick       (tick)
    );

    //////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= TX_IDLE;
            bit_idx <= '0;
            uart_tx <= 1'b1;
        end else begin
            case (state)
                TX_SHIFT: begin
                    // Each tick closes the previous bit, the ninth closes bit 7
                    if (tick) begin
                        if (bit_idx == 4'd8) begin
                            uart_tx <= 1'b1;
                            bit_idx <= '0;
                            state   <= TX_STOP;
                        end else begin
                            uart_tx <= shreg[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    // Line stays high, a second period follows in two-stop mode
                    if (tick) begin
                        if (stop_mode && bit_idx == 4'd0) begin
                            bit_idx <= 4'd1;
                        end else begin
                            bit_idx <= '0;
                            state   <= TX_IDLE;
                        end
                    end
                end
                default: begin
                    if (start) begin
                        uart_tx <= 1'b0;
                        bit_idx <= '0;
                        state   <= TX_SHIFT;
                    end
                end
            endcase
        end
    end

    // Data byte, shifted right as each bit goes out
    always_ff @(posedge aclk) begin
        if (start)
            shreg <= fifo.rdata;
        else if (state == TX_SHIFT && tick)
            shreg <= shreg >> 1;
    end

endmodule

`default_nettype wire

/* testbench/tb_uart.sv */
// Reads its commands from testbench/uart_input.txt, so it runs from the project root
// The divider on S and B lines must match the divider last written to the DUT
`timescale 1ns/1ns
`default_nettype none

module tb_uart import uart_pkg::*; ();

    localparam int unsigned SEED          = 32'h1bba0b1d;
    localparam int          BUS_TIMEOUT   = 1000;
    localparam int          RTS_TIMEOUT   = 2000;
    localparam int          DRAIN_TIMEOUT = 5000;

    logic  aclk;
    logic  aresetn;
    logic  slv_en;
    logic  slv_wr;
    addr_t slv_addr;
    word_t slv_wdata;
    strb_t slv_strb;
    word_t slv_rdata;
    logic  slv_ready;
    logic  uart_rx;
    logic  uart_tx;
    logic  uart_rts;
    logic  uart_cts;

    // Frame format as last written, for the TX decoder
    div_t  cfg_div;
    logic  cfg_stop;

    int    tb_errors;
    int    pass_count;
    int    fail_count;
    int    test_base;
    logic  in_test;
    logic [8*24-1:0] test_name;
    time   last_ready_t;
    time   stop_start_t;

    uart_top i_uart_top (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .slv_en    (slv_en),
        .slv_wr    (slv_wr),
        .slv_addr  (slv_addr),
        .slv_wdata (slv_wdata),
        .slv_strb  (slv_strb),
        .slv_rdata (slv_rdata),
        .slv_ready (slv_ready),
        .uart_rx   (uart_rx),
        .uart_tx   (uart_tx),
        .uart_rts  (uart_rts),
        .uart_cts  (uart_cts)
    );

    uart_checker i_uart_checker (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .slv_ready (slv_ready),
        .slv_wr    (slv_wr),
        .slv_addr  (slv_addr),
        .slv_rdata (slv_rdata),
        .uart_tx   (uart_tx),
        .uart_rts  (uart_rts),
        .cfg_div   (cfg_div),
        .cfg_stop  (cfg_stop)
    );

    // 4 ns clock period
    always #2 aclk = ~aclk;

    function automatic int error_total();
        return tb_errors + i_uart_checker.errors;
    endfunction

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Register bus
    //////////////////////////////////////////////////

    task automatic bus_access(input logic wr, input addr_t addr, input word_t data,
                              input strb_t strb);
        int   cycles;
        logic seen;
        // A short random gap between requests
        repeat ($urandom % 3) @(posedge aclk);
        step();
        slv_en    = 1'b1;
        slv_wr    = wr;
        slv_addr  = addr;
        slv_wdata = data;
        slv_strb  = strb;
        cycles    = 0;
        seen      = 1'b0;
        // The request stays up until the one-cycle ready pulse
        while (!seen && cycles < BUS_TIMEOUT) begin
            @(negedge aclk);
            if (slv_ready === 1'b1)
                seen = 1'b1;
            else
                cycles++;
        end
        if (seen) begin
            last_ready_t = $time;
        end else begin
            $display("Bus access to address %h got no slv_ready within %0d cycles",
                     addr, BUS_TIMEOUT);
            tb_errors++;
        end
        step();
        slv_en = 1'b0;
        slv_wr = 1'b0;
    endtask

    task automatic bus_write(input addr_t addr, input word_t data, input strb_t strb);
        // Track the frame format with the same strobe rules as the register map
        if (addr == ADDR_DIV) begin
            if (strb[0])
                cfg_div[7:0] = data[7:0];
            if (strb[1])
                cfg_div[15:8] = data[15:8];
        end else if (addr == ADDR_CTRL && strb[0]) begin
            cfg_stop = data[CTRL_STOP_MODE];
        end
        bus_access(1'b1, addr, data, strb);
    endtask

    task automatic bus_read(input addr_t addr, input word_t want);
        i_uart_checker.expect_read(want);
        bus_access(1'b0, addr, '0, '0);
    endtask

    //////////////////////////////////////////////////
    // Serial side
    //////////////////////////////////////////////////

    task automatic hold_bit(input logic level, input div_t div);
        uart_rx = level;
        repeat (int'(div) + 1) @(posedge aclk);
        #1;
    endtask

    task automatic send_serial(input div_t div, input byte_t data);
        int cycles;
        int i;
        cycles = 0;
        step();
        // The remote sender honours RTS before each frame
        while (uart_rts !== 1'b1 && cycles < RTS_TIMEOUT) begin
            step();
            cycles++;
        end
        if (uart_rts !== 1'b1) begin
            $display("Gave up at %0t waiting for uart_rts to rise before a serial byte", $time);
            tb_errors++;
        end
        hold_bit(1'b0, div);
        for (i = 0; i < 8; i++)
            hold_bit(data[i], div);
        stop_start_t = $time;
        hold_bit(1'b1, div);
        // One idle bit between frames
        hold_bit(1'b1, div);
    endtask

    task automatic set_cts(input logic level);
        step();
        uart_cts = level;
        // Give the two-flop synchronizer time to pass the new level
        repeat (3) @(posedge aclk);
    endtask

    task automatic wait_tx_drained();
        int cycles;
        cycles = 0;
        while (i_uart_checker.tx_pending() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            cycles++;
        end
        if (i_uart_checker.tx_pending() != 0) begin
            $display("Gave up at %0t with %0d expected bytes never seen on uart_tx",
                     $time, i_uart_checker.tx_pending());
            tb_errors++;
        end
    endtask

    // The RX read goes out first and must hold until the late byte lands
    task automatic read_waits_for_byte(input div_t div, input byte_t data);
        i_uart_checker.expect_read(word_t'(data));
        fork
            bus_access(1'b0, ADDR_RXDATA, '0, '0);
            begin
                repeat (20) @(posedge aclk);
                send_serial(div, data);
            end
        join
        if (last_ready_t <= stop_start_t) begin
            $display("The RX read finished at %0t before its byte was received", last_ready_t);
            tb_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Command file
    //////////////////////////////////////////////////

    task automatic close_test();
        int errs;
        if (in_test) begin
            errs = error_total() - test_base;
            if (errs == 0) begin
                pass_count++;
                $display("Test %0s passed", test_name);
            end else begin
                fail_count++;
                $display("Test %0s failed with %0d errors", test_name, errs);
            end
        end
        in_test = 1'b0;
    endtask

    task automatic run_command(input int fd, input logic [7:0] cmd);
        int               code;
        word_t            f1;
        word_t            f2;
        word_t            f3;
        logic [8*128-1:0] skip_buf;
        logic [8*24-1:0]  name_buf;
        case (cmd)
            "#": code = $fgets(skip_buf, fd);
            "N": begin
                code = $fscanf(fd, "%s", name_buf);
                close_test();
                test_name = name_buf;
                test_base = error_total();
                in_test   = 1'b1;
            end
            "W": begin
                code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                bus_write(addr_t'(f1), f2, strb_t'(f3));
            end
            "R": begin
                code = $fscanf(fd, "%h %h", f1, f2);
                bus_read(addr_t'(f1), f2);
            end
            "S": begin
                code = $fscanf(fd, "%h %h", f1, f2);
                send_serial(div_t'(f1), byte_t'(f2));
            end
            "B": begin
                code = $fscanf(fd, "%h %h", f1, f2);
                read_waits_for_byte(div_t'(f1), byte_t'(f2));
            end
            "T": begin
                code = $fscanf(fd, "%h", f1);
                i_uart_checker.expect_tx(byte_t'(f1));
            end
            "C": begin
                code = $fscanf(fd, "%h", f1);
                set_cts(f1[0]);
            end
            "P": begin
                code = $fscanf(fd, "%h", f1);
                i_uart_checker.check_rts(f1[0]);
            end
            "D": wait_tx_drained();
            default: begin
                $display("Unknown command %c in the input file", cmd);
                tb_errors++;
            end
        endcase
    endtask

    initial begin
        int         fd;
        int         code;
        logic [7:0] cmd;
        aclk         = 1'b0;
        aresetn      = 1'b0;
        slv_en       = 1'b0;
        slv_wr       = 1'b0;
        slv_addr     = '0;
        slv_wdata    = '0;
        slv_strb     = '0;
        uart_rx      = 1'b1;
        uart_cts     = 1'b1;
        cfg_div      = DIV_RESET;
        cfg_stop     = 1'b0;
        tb_errors    = 0;
        pass_count   = 0;
        fail_count   = 0;
        test_base    = 0;
        in_test      = 1'b0;
        test_name    = '0;
        last_ready_t = 0;
        stop_start_t = 0;
        code         = $urandom(SEED);
        repeat (4) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        fd = $fopen("testbench/uart_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/uart_input.txt");
            tb_errors++;
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1)
                run_command(fd, cmd);
            $fclose(fd);
        end
        close_test();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (error_total() == 0 && fail_count == 0 && pass_count > 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/uart_checker.sv */
// Decodes 8-bit frames without parity and expects the divider to stay fixed during a frame
// Reads are compared in issue order, so only one bus access may be in flight at a time
`timescale 1ns/1ns
`default_nettype none

module uart_checker import uart_pkg::*; (
    input logic  aclk,
    input logic  aresetn,
    input logic  slv_ready,
    input logic  slv_wr,
    input addr_t slv_addr,
    input word_t slv_rdata,
    input logic  uart_tx,
    input logic  uart_rts,
    input div_t  cfg_div,
    input logic  cfg_stop
);

    // Expected values, filled by the test top from the command file
    word_t rd_expected [$];
    byte_t tx_expected [$];
    logic  line_prev = 1'b1;
    int    errors    = 0;

    task automatic expect_read(input word_t value);
        rd_expected.push_back(value);
    endtask

    task automatic expect_tx(input byte_t value);
        tx_expected.push_back(value);
    endtask

    // Bytes still waiting to show up on the serial line
    function automatic int tx_pending();
        return tx_expected.size();
    endfunction

    //////////////////////////////////////////////////
    // Bus read checking
    //////////////////////////////////////////////////

    task automatic check_read();
        word_t want;
        if (rd_expected.size() == 0) begin
            $display("A bus read from %h completed at %0t with no value expected",
                     slv_addr, $time);
            errors++;
        end else begin
            want = rd_expected.pop_front();
            if (slv_rdata !== want) begin
                $display("Mismatch at %0t: slv_rdata from %h is %h, expected %h",
                         $time, slv_addr, slv_rdata, want);
                errors++;
            end
        end
    endtask

    // Write requests keep slv_wr high through the ready cycle
    always @(negedge aclk) begin
        if (aresetn && slv_ready === 1'b1 && slv_wr === 1'b0)
            check_read();
    end

    // Flow-control level at the port, sampled on the next falling edge
    task automatic check_rts(input logic level);
        @(negedge aclk);
        if (uart_rts !== level) begin
            $display("Mismatch at %0t: uart_rts is %b, expected %b", $time, uart_rts, level);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // TX frame decoding
    //////////////////////////////////////////////////

    // Stop bits are sampled in their middle and must be high
    task automatic check_stop(input int index);
        if (uart_tx !== 1'b1) begin
            $display("Mismatch at %0t: uart_tx stop bit %0d is %b, expected 1",
                     $time, index, uart_tx);
            errors++;
        end
    endtask

    task automatic decode_frame();
        int    period;
        int    i;
        logic  two_stop;
        byte_t data;
        byte_t want;
        period   = int'(cfg_div) + 1;
        two_stop = cfg_stop;
        // Half a cycle is already gone, this lands near the middle of the start bit
        repeat (period / 2) @(negedge aclk);
        if (uart_tx !== 1'b0) begin
            $display("Mismatch at %0t: uart_tx start bit is %b, expected 0", $time, uart_tx);
            errors++;
        end
        // Data goes out LSB first
        for (i = 0; i < 8; i++) begin
            repeat (period) @(negedge aclk);
            data[i] = uart_tx;
        end
        repeat (period) @(negedge aclk);
        check_stop(1);
        // In one-stop mode the next start bit would sit here and read low
        if (two_stop) begin
            repeat (period) @(negedge aclk);
            check_stop(2);
        end
        // Let the last stop bit run out so the engine is idle when the queue drains
        repeat (period / 2) @(negedge aclk);
        if (tx_expected.size() == 0) begin
            $display("A frame with byte %h appeared on uart_tx at %0t with no byte expected",
                     data, $time);
            errors++;
        end else begin
            want = tx_expected.pop_front();
            if (data !== want) begin
                $display("Mismatch at %0t: uart_tx byte is %h, expected %h", $time, data, want);
                errors++;
            end
        end
    endtask

    // A falling edge on the idle line marks a start bit
    always begin
        @(negedge aclk);
        if (aresetn && line_prev === 1'b1 && uart_tx === 1'b0)
            decode_frame();
        line_prev = uart_tx;
    end

endmodule

`default_nettype wire

/* testbench/uart_input.txt */
# Columns: command, then hex fields. N name | W addr data strb | R addr expected | T byte
# S div byte | B div byte (RX read before the byte) | C cts | P rts | D waits for TX to drain
N reset_values
R 0000 00006a01
R 0004 00000004
R 0010 ffffffff
N divider_strobes
W 0004 0000ab12 1
R 0004 00000012
W 0004 00003400 2
R 0004 00003412
W 0004 00000007 3
R 0004 00000007
N tx_frames
T a5
T 3c
W 0008 000000a5 1
W 0008 0000003c 1
D
W 0000 00000011 1
R 0000 00006a11
T 5a
T c3
W 0008 0000005a 1
W 0008 000000c3 1
D
W 0000 00000001 1
N tx_cts_hold
C 0
W 0008 00000011 1
W 0008 00000022 1
W 0008 00000033 1
W 0008 00000044 1
R 0000 00002c01
T 11
T 22
T 33
T 44
C 1
D
N rx_backpressure
S 0007 81
S 0007 7e
S 0007 00
S 0007 ff
P 0
R 0000 00005201
R 000c 00000081
R 000c 0000007e
R 000c 00000000
R 000c 000000ff
P 1
R 0000 00006a01
N rx_read_stall
B 0007 a7
R 0000 00006a01
